// ==== ip_arp_switch.f ====
eth_pkg.sv
eth_type_demux.sv
eth_tx_arb.sv
eth_payload_skid.sv
ip_arp_switch.sv
tb_ip_arp_switch.sv

// ==== Makefile ====
VERILATOR    = verilator
FILELIST     = ip_arp_switch.f
TB_TOP       = tb_ip_arp_switch
RTL_TOP      = ip_arp_switch
COMMON_FLAGS = --timing --timescale 1ns/10ps
LINT_FLAGS   = --lint-only -Wall
SIM_FLAGS    = --binary -Mdir obj_dir
LOG          = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(COMMON_FLAGS) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(COMMON_FLAGS) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)
	./obj_dir/V$(TB_TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_ip_arp_switch.sv ====
// Directed testbench for the IPv4/ARP switch.
// Acts as MAC and as both engines; outputs are collected into queues
// per port and compared against frames built here.
// Random bytes and ready patterns use an xorshift generator.
`timescale 1ns/10ps
`default_nettype none

module tb_ip_arp_switch import eth_pkg::*; ();

  localparam eth_type_t TYPE_IPV4  = 16'h0800;
  localparam eth_type_t TYPE_ARP   = 16'h0806;
  localparam eth_type_t TYPE_OTHER = 16'h86dd;
  // Frame sources and output ports
  localparam int SRC_RX   = 0;
  localparam int SRC_ARP  = 1;
  localparam int SRC_IP   = 2;
  localparam int PORT_IP  = 0;
  localparam int PORT_ARP = 1;
  localparam int PORT_TX  = 2;
  // Sum of all frame lengths sent below
  localparam int RX_BEATS = 6 + 4 + 5 + 3 + 20;
  localparam int TX_BEATS = 4 + 5 + 4 * 8;
  localparam int FRAMES = 15;
  localparam int STALL_MARGIN = 8;
  localparam int WATCHDOG_CYCLES = (RX_BEATS + TX_BEATS + 4 * FRAMES) * STALL_MARGIN + 100;

  logic      clk = 1'b0;
  logic      rst;
  eth_hdr_t  rx_hdr;
  logic      rx_hdr_valid;
  logic      rx_hdr_ready;
  eth_beat_t rx_beat;
  logic      rx_valid;
  logic      rx_ready;
  eth_hdr_t  ip_rx_hdr;
  logic      ip_rx_hdr_valid;
  logic      ip_rx_hdr_ready = 1'b1;
  eth_beat_t ip_rx_beat;
  logic      ip_rx_valid;
  logic      ip_rx_ready = 1'b1;
  eth_hdr_t  arp_rx_hdr;
  logic      arp_rx_hdr_valid;
  logic      arp_rx_hdr_ready = 1'b1;
  eth_beat_t arp_rx_beat;
  logic      arp_rx_valid;
  logic      arp_rx_ready = 1'b1;
  eth_hdr_t  arp_tx_hdr;
  logic      arp_tx_hdr_valid;
  logic      arp_tx_hdr_ready;
  eth_beat_t arp_tx_beat;
  logic      arp_tx_valid;
  logic      arp_tx_ready;
  eth_hdr_t  ip_tx_hdr;
  logic      ip_tx_hdr_valid;
  logic      ip_tx_hdr_ready;
  eth_beat_t ip_tx_beat;
  logic      ip_tx_valid;
  logic      ip_tx_ready;
  eth_hdr_t  eth_tx_hdr;
  logic      eth_tx_hdr_valid;
  logic      eth_tx_hdr_ready = 1'b1;
  eth_beat_t eth_tx_beat;
  logic      eth_tx_valid;
  logic      eth_tx_ready = 1'b1;

  int          errors = 0;
  logic [31:0] rng_state = 32'd96;
  bit          stall_rx = 1'b0;
  bit          stall_tx = 1'b0;
  string       port_name [3] = '{"ip_rx", "arp_rx", "eth_tx"};
  eth_hdr_t    src_hdr [3];
  eth_beat_t   src_beats [3][$];
  eth_hdr_t    exp_hdr [3][$];
  eth_hdr_t    got_hdr [3][$];
  eth_beat_t   exp_beat [3][$];
  eth_beat_t   got_beat [3][$];

  ip_arp_switch dut0 (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Sink ready patterns stay high unless a test stalls them
  always @(posedge clk) begin
    logic [31:0] r;
    r = xorshift();
    ip_rx_ready      <= !stall_rx || r[0];
    eth_tx_ready     <= !stall_tx || r[1];
    eth_tx_hdr_ready <= !stall_tx || r[2];
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (ip_rx_hdr_valid && ip_rx_hdr_ready) got_hdr[PORT_IP].push_back(ip_rx_hdr);
      if (ip_rx_valid && ip_rx_ready) got_beat[PORT_IP].push_back(ip_rx_beat);
      if (arp_rx_hdr_valid && arp_rx_hdr_ready) got_hdr[PORT_ARP].push_back(arp_rx_hdr);
      if (arp_rx_valid && arp_rx_ready) got_beat[PORT_ARP].push_back(arp_rx_beat);
      if (eth_tx_hdr_valid && eth_tx_hdr_ready) got_hdr[PORT_TX].push_back(eth_tx_hdr);
      if (eth_tx_valid && eth_tx_ready) got_beat[PORT_TX].push_back(eth_tx_beat);
    end
  end

  task compare_hdr(input eth_hdr_t got, input eth_hdr_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s header %h, expected %h", $time, what, got, exp);
    end
  endtask

  task compare_beat(input eth_beat_t got, input eth_beat_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s beat data %h last %b user %b, expected %h %b %b",
               $time, what, got.data, got.last, got.user, exp.data, exp.last, exp.user);
    end
  endtask

  task make_frame(input int src, input eth_type_t typ, input int len, input logic bad);
    logic [31:0] r1;
    logic [31:0] r2;
    eth_beat_t   b;
    int          i;
    r1 = xorshift();
    r2 = xorshift();
    src_hdr[src].dest_mac = {r1[15:0], r2};
    src_hdr[src].src_mac  = {r2[15:0], r1};
    src_hdr[src].eth_type = typ;
    src_beats[src].delete();
    for (i = 0; i < len; i++) begin
      r1 = xorshift();
      b.data = r1[7:0];
      b.last = (i == len - 1);
      b.user = b.last && bad;
      src_beats[src].push_back(b);
    end
  endtask

  task expect_frame(input int src, input int port);
    int i;
    exp_hdr[port].push_back(src_hdr[src]);
    for (i = 0; i < src_beats[src].size(); i++) begin
      exp_beat[port].push_back(src_beats[src][i]);
    end
  endtask

  task send_rx_frame(input logic check_ready);
    int i;
    rx_hdr       <= src_hdr[SRC_RX];
    rx_hdr_valid <= 1'b1;
    @(posedge clk);
    while (!rx_hdr_ready) @(posedge clk);
    rx_hdr_valid <= 1'b0;
    for (i = 0; i < src_beats[SRC_RX].size(); i++) begin
      rx_beat  <= src_beats[SRC_RX][i];
      rx_valid <= 1'b1;
      @(posedge clk);
      if (check_ready && !rx_ready) begin
        errors++;
        $display("error at %0t: rx_ready was low for a beat of a dropped frame", $time);
      end
      while (!rx_ready) @(posedge clk);
    end
    rx_valid <= 1'b0;
  endtask

  task send_arp_tx;
    int i;
    arp_tx_hdr       <= src_hdr[SRC_ARP];
    arp_tx_hdr_valid <= 1'b1;
    @(posedge clk);
    while (!arp_tx_hdr_ready) @(posedge clk);
    arp_tx_hdr_valid <= 1'b0;
    for (i = 0; i < src_beats[SRC_ARP].size(); i++) begin
      arp_tx_beat  <= src_beats[SRC_ARP][i];
      arp_tx_valid <= 1'b1;
      @(posedge clk);
      while (!arp_tx_ready) @(posedge clk);
    end
    arp_tx_valid <= 1'b0;
  endtask

  task send_ip_tx;
    int i;
    ip_tx_hdr       <= src_hdr[SRC_IP];
    ip_tx_hdr_valid <= 1'b1;
    @(posedge clk);
    while (!ip_tx_hdr_ready) @(posedge clk);
    ip_tx_hdr_valid <= 1'b0;
    for (i = 0; i < src_beats[SRC_IP].size(); i++) begin
      ip_tx_beat  <= src_beats[SRC_IP][i];
      ip_tx_valid <= 1'b1;
      @(posedge clk);
      while (!ip_tx_ready) @(posedge clk);
    end
    ip_tx_valid <= 1'b0;
  endtask

  // Waits until every port has delivered what is expected and then compares
  task check_outputs(input string name);
    bit pending;
    int p;
    int i;
    pending = 1'b1;
    while (pending) begin
      @(posedge clk);
      pending = 1'b0;
      for (p = 0; p < 3; p++) begin
        if (got_hdr[p].size() < exp_hdr[p].size()) pending = 1'b1;
        if (got_beat[p].size() < exp_beat[p].size()) pending = 1'b1;
      end
    end
    // A few idle cycles so stray outputs show up too
    repeat (4) @(posedge clk);
    for (p = 0; p < 3; p++) begin
      if (got_hdr[p].size() != exp_hdr[p].size()) begin
        errors++;
        $display("error at %0t: %s on %s carried %0d headers, expected %0d", $time, name,
                 port_name[p], got_hdr[p].size(), exp_hdr[p].size());
      end else begin
        for (i = 0; i < exp_hdr[p].size(); i++) begin
          compare_hdr(got_hdr[p][i], exp_hdr[p][i], {name, " ", port_name[p]});
        end
      end
      if (got_beat[p].size() != exp_beat[p].size()) begin
        errors++;
        $display("error at %0t: %s on %s carried %0d beats, expected %0d", $time, name,
                 port_name[p], got_beat[p].size(), exp_beat[p].size());
      end else begin
        for (i = 0; i < exp_beat[p].size(); i++) begin
          compare_beat(got_beat[p][i], exp_beat[p][i], {name, " ", port_name[p]});
        end
      end
      got_hdr[p].delete();
      exp_hdr[p].delete();
      got_beat[p].delete();
      exp_beat[p].delete();
    end
  endtask

  task test_ipv4_rx;
    make_frame(SRC_RX, TYPE_IPV4, 6, 1'b1);
    expect_frame(SRC_RX, PORT_IP);
    send_rx_frame(1'b0);
    check_outputs("ipv4 rx");
  endtask

  task test_arp_rx;
    make_frame(SRC_RX, TYPE_ARP, 4, 1'b0);
    expect_frame(SRC_RX, PORT_ARP);
    send_rx_frame(1'b0);
    check_outputs("arp rx");
  endtask

  task test_drop_unknown;
    make_frame(SRC_RX, TYPE_OTHER, 5, 1'b0);
    send_rx_frame(1'b1);
    make_frame(SRC_RX, TYPE_IPV4, 3, 1'b0);
    expect_frame(SRC_RX, PORT_IP);
    send_rx_frame(1'b0);
    check_outputs("drop then ipv4");
  endtask

  task test_rx_backpressure;
    stall_rx = 1'b1;
    make_frame(SRC_RX, TYPE_IPV4, 20, 1'b0);
    expect_frame(SRC_RX, PORT_IP);
    send_rx_frame(1'b0);
    check_outputs("rx backpressure");
    stall_rx = 1'b0;
  endtask

  task test_tx_priority;
    make_frame(SRC_ARP, TYPE_ARP, 4, 1'b0);
    make_frame(SRC_IP, TYPE_IPV4, 5, 1'b1);
    // ARP wins when both arrive together
    expect_frame(SRC_ARP, PORT_TX);
    expect_frame(SRC_IP, PORT_TX);
    fork
      send_arp_tx;
      send_ip_tx;
    join
    check_outputs("tx priority");
  endtask

  task test_tx_random;
    int k;
    stall_tx = 1'b1;
    for (k = 0; k < 4; k++) begin
      make_frame(SRC_ARP, TYPE_ARP, 2 + k, 1'b0);
      make_frame(SRC_IP, TYPE_IPV4, 6 - k, k[0]);
      expect_frame(SRC_ARP, PORT_TX);
      expect_frame(SRC_IP, PORT_TX);
      fork
        send_arp_tx;
        send_ip_tx;
      join
    end
    check_outputs("tx random ready");
    stall_tx = 1'b0;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

  initial begin
    rst              <= 1'b1;
    rx_hdr           <= '0;
    rx_hdr_valid     <= 1'b0;
    rx_beat          <= '0;
    rx_valid         <= 1'b0;
    arp_tx_hdr       <= '0;
    arp_tx_hdr_valid <= 1'b0;
    arp_tx_beat      <= '0;
    arp_tx_valid     <= 1'b0;
    ip_tx_hdr        <= '0;
    ip_tx_hdr_valid  <= 1'b0;
    ip_tx_beat       <= '0;
    ip_tx_valid      <= 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_ipv4_rx;
    test_arp_rx;
    test_drop_unknown;
    test_rx_backpressure;
    test_tx_priority;
    test_tx_random;
    $display("Finished with %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ip_arp_switch.sv ====
// Ethernet switch between one MAC port and the IPv4 and ARP engines.
// Receive path is combinational; transmit beats gain one cycle in the
// register slice. Frames of unknown ethertype are dropped.
`timescale 1ns/10ps
`default_nettype none

module ip_arp_switch import eth_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  // From MAC
  input  eth_hdr_t   rx_hdr,
  input  wire        rx_hdr_valid,
  output logic       rx_hdr_ready,
  input  eth_beat_t  rx_beat,
  input  wire        rx_valid,
  output logic       rx_ready,
  // To engines
  output eth_hdr_t   ip_rx_hdr,
  output logic       ip_rx_hdr_valid,
  input  wire        ip_rx_hdr_ready,
  output eth_beat_t  ip_rx_beat,
  output logic       ip_rx_valid,
  input  wire        ip_rx_ready,
  output eth_hdr_t   arp_rx_hdr,
  output logic       arp_rx_hdr_valid,
  input  wire        arp_rx_hdr_ready,
  output eth_beat_t  arp_rx_beat,
  output logic       arp_rx_valid,
  input  wire        arp_rx_ready,
  // From engines
  input  eth_hdr_t   arp_tx_hdr,
  input  wire        arp_tx_hdr_valid,
  output logic       arp_tx_hdr_ready,
  input  eth_beat_t  arp_tx_beat,
  input  wire        arp_tx_valid,
  output logic       arp_tx_ready,
  input  eth_hdr_t   ip_tx_hdr,
  input  wire        ip_tx_hdr_valid,
  output logic       ip_tx_hdr_ready,
  input  eth_beat_t  ip_tx_beat,
  input  wire        ip_tx_valid,
  output logic       ip_tx_ready,
  // To MAC
  output eth_hdr_t   eth_tx_hdr,
  output logic       eth_tx_hdr_valid,
  input  wire        eth_tx_hdr_ready,
  output eth_beat_t  eth_tx_beat,
  output logic       eth_tx_valid,
  input  wire        eth_tx_ready
);

  eth_beat_t arb_beat;
  logic      arb_valid;
  logic      arb_ready;

  eth_type_demux demux0 (
    .clk           (clk),
    .rst           (rst),
    .rx_hdr        (rx_hdr),
    .rx_hdr_valid  (rx_hdr_valid),
    .rx_hdr_ready  (rx_hdr_ready),
    .rx_beat       (rx_beat),
    .rx_valid      (rx_valid),
    .rx_ready      (rx_ready),
    .ip_hdr        (ip_rx_hdr),
    .ip_hdr_valid  (ip_rx_hdr_valid),
    .ip_hdr_ready  (ip_rx_hdr_ready),
    .ip_beat       (ip_rx_beat),
    .ip_valid      (ip_rx_valid),
    .ip_ready      (ip_rx_ready),
    .arp_hdr       (arp_rx_hdr),
    .arp_hdr_valid (arp_rx_hdr_valid),
    .arp_hdr_ready (arp_rx_hdr_ready),
    .arp_beat      (arp_rx_beat),
    .arp_valid     (arp_rx_valid),
    .arp_ready     (arp_rx_ready)
  );

  eth_tx_arb arb0 (
    .clk           (clk),
    .rst           (rst),
    .arp_hdr       (arp_tx_hdr),
    .arp_hdr_valid (arp_tx_hdr_valid),
    .arp_hdr_ready (arp_tx_hdr_ready),
    .arp_beat      (arp_tx_beat),
    .arp_valid     (arp_tx_valid),
    .arp_ready     (arp_tx_ready),
    .ip_hdr        (ip_tx_hdr),
    .ip_hdr_valid  (ip_tx_hdr_valid),
    .ip_hdr_ready  (ip_tx_hdr_ready),
    .ip_beat       (ip_tx_beat),
    .ip_valid      (ip_tx_valid),
    .ip_ready      (ip_tx_ready),
    .tx_hdr        (eth_tx_hdr),
    .tx_hdr_valid  (eth_tx_hdr_valid),
    .tx_hdr_ready  (eth_tx_hdr_ready),
    .beat          (arb_beat),
    .beat_valid    (arb_valid),
    .beat_ready    (arb_ready)
  );

  eth_payload_skid skid0 (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (arb_beat),
    .in_valid  (arb_valid),
    .in_ready  (arb_ready),
    .out_beat  (eth_tx_beat),
    .out_ready (eth_tx_ready),
    .out_valid (eth_tx_valid)
  );

endmodule

`default_nettype wire

// ==== eth_payload_skid.sv ====
// Two-entry register slice for the transmit payload.
// One cycle of latency, full throughput; in_ready comes from a flop.
`timescale 1ns/10ps
`default_nettype none

module eth_payload_skid import eth_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  input  eth_beat_t  in_beat,
  input  wire        in_valid,
  output logic       in_ready,
  output eth_beat_t  out_beat,
  input  wire        out_ready,
  output logic       out_valid
);

  eth_beat_t main_q;
  eth_beat_t spare_q;
  logic      main_valid_q;
  logic      spare_valid_q;
  logic      in_xfer;
  logic      main_load;

  assign in_ready  = !spare_valid_q;
  assign out_beat  = main_q;
  assign out_valid = main_valid_q;

  assign in_xfer   = in_valid && in_ready;
  assign main_load = out_ready || !main_valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (main_load) begin
      // Spare drains first while input is held off
      main_valid_q  <= spare_valid_q || in_xfer;
      spare_valid_q <= 1'b0;
    end else if (in_xfer) begin
      spare_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      main_q <= spare_valid_q ? spare_q : in_beat;
    end
    if (!main_load && in_xfer) begin
      spare_q <= in_beat;
    end
  end

endmodule

`default_nettype wire

// ==== eth_tx_arb.sv ====
// Transmit arbiter in which ARP has fixed priority over IP.
// The grant is held for a whole frame, so frames never interleave.
// The header leaves from a register one cycle after it is accepted;
// beats of the granted source pass through combinationally.
`timescale 1ns/10ps
`default_nettype none

module eth_tx_arb import eth_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  input  eth_hdr_t   arp_hdr,
  input  wire        arp_hdr_valid,
  output logic       arp_hdr_ready,
  input  eth_beat_t  arp_beat,
  input  wire        arp_valid,
  output logic       arp_ready,
  input  eth_hdr_t   ip_hdr,
  input  wire        ip_hdr_valid,
  output logic       ip_hdr_ready,
  input  eth_beat_t  ip_beat,
  input  wire        ip_valid,
  output logic       ip_ready,
  output eth_hdr_t   tx_hdr,
  output logic       tx_hdr_valid,
  input  wire        tx_hdr_ready,
  output eth_beat_t  beat,
  output logic       beat_valid,
  input  wire        beat_ready
);

  arb_state_t state_q;
  logic       done_q;
  eth_hdr_t   hdr_q;
  logic       hdr_valid_q;
  logic       last_xfer;
  logic       hdr_free;
  logic       frame_done;
  logic       frame_end;
  logic       can_accept;
  logic       grant_arp;
  logic       grant_ip;

  // Beats flow only until the last one of the granted frame
  always_comb begin
    beat       = ip_beat;
    beat_valid = 1'b0;
    arp_ready  = 1'b0;
    ip_ready   = 1'b0;
    if (!done_q) begin
      case (state_q)
        ARB_ARP: begin
          beat       = arp_beat;
          beat_valid = arp_valid;
          arp_ready  = beat_ready;
        end
        ARB_IP: begin
          beat       = ip_beat;
          beat_valid = ip_valid;
          ip_ready   = beat_ready;
        end
        default: begin
          beat_valid = 1'b0;
        end
      endcase
    end
  end

  assign last_xfer  = beat_valid && beat_ready && beat.last;
  assign hdr_free   = !hdr_valid_q || tx_hdr_ready;
  assign frame_done = (state_q != ARB_IDLE) && (done_q || last_xfer);
  assign frame_end  = frame_done && hdr_free;

  // Next header may be taken in the cycle the current frame ends
  assign can_accept = hdr_free && ((state_q == ARB_IDLE) || frame_done);
  assign grant_arp  = can_accept && arp_hdr_valid;
  assign grant_ip   = can_accept && !arp_hdr_valid && ip_hdr_valid;

  assign arp_hdr_ready = can_accept;
  assign ip_hdr_ready  = can_accept && !arp_hdr_valid;

  assign tx_hdr       = hdr_q;
  assign tx_hdr_valid = hdr_valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ARB_IDLE;
      done_q      <= 1'b0;
      hdr_valid_q <= 1'b0;
    end else if (grant_arp || grant_ip) begin
      state_q     <= grant_arp ? ARB_ARP : ARB_IP;
      done_q      <= 1'b0;
      hdr_valid_q <= 1'b1;
    end else begin
      if (frame_end) begin
        state_q <= ARB_IDLE;
        done_q  <= 1'b0;
      end else if (last_xfer) begin
        done_q <= 1'b1;
      end
      if (tx_hdr_ready) begin
        hdr_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_arp) begin
      hdr_q <= arp_hdr;
    end else if (grant_ip) begin
      hdr_q <= ip_hdr;
    end
  end

endmodule

`default_nettype wire

// ==== eth_type_demux.sv ====
// Receive classifier. Headers are steered by ethertype with no latency.
// IPv4 goes to the ip port, ARP to the arp port, anything else is
// consumed and dropped. The route is held until the last beat; a new
// header is not accepted before then.
`timescale 1ns/10ps
`default_nettype none

module eth_type_demux import eth_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  input  eth_hdr_t   rx_hdr,
  input  wire        rx_hdr_valid,
  output logic       rx_hdr_ready,
  input  eth_beat_t  rx_beat,
  input  wire        rx_valid,
  output logic       rx_ready,
  output eth_hdr_t   ip_hdr,
  output logic       ip_hdr_valid,
  input  wire        ip_hdr_ready,
  output eth_beat_t  ip_beat,
  output logic       ip_valid,
  input  wire        ip_ready,
  output eth_hdr_t   arp_hdr,
  output logic       arp_hdr_valid,
  input  wire        arp_hdr_ready,
  output eth_beat_t  arp_beat,
  output logic       arp_valid,
  input  wire        arp_ready
);

  route_t route_q;
  logic   is_ip;
  logic   is_arp;
  logic   idle;
  logic   hdr_xfer;
  logic   last_xfer;

  assign is_ip  = (rx_hdr.eth_type == ETH_TYPE_IPV4);
  assign is_arp = (rx_hdr.eth_type == ETH_TYPE_ARP);
  assign idle   = (route_q == ROUTE_IDLE);

  // Header offered only to the matching port
  assign ip_hdr        = rx_hdr;
  assign arp_hdr       = rx_hdr;
  assign ip_hdr_valid  = idle && rx_hdr_valid && is_ip;
  assign arp_hdr_valid = idle && rx_hdr_valid && is_arp;

  always_comb begin
    rx_hdr_ready = 1'b0;
    if (idle) begin
      if (is_ip) begin
        rx_hdr_ready = ip_hdr_ready;
      end else if (is_arp) begin
        rx_hdr_ready = arp_hdr_ready;
      end else begin
        rx_hdr_ready = 1'b1;
      end
    end
  end

  assign ip_beat   = rx_beat;
  assign arp_beat  = rx_beat;
  assign ip_valid  = (route_q == ROUTE_IP) && rx_valid;
  assign arp_valid = (route_q == ROUTE_ARP) && rx_valid;

  always_comb begin
    case (route_q)
      ROUTE_IP:   rx_ready = ip_ready;
      ROUTE_ARP:  rx_ready = arp_ready;
      ROUTE_DROP: rx_ready = 1'b1;
      default:    rx_ready = 1'b0;
    endcase
  end

  assign hdr_xfer  = rx_hdr_valid && rx_hdr_ready;
  assign last_xfer = rx_valid && rx_ready && rx_beat.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      route_q <= ROUTE_IDLE;
    end else if (hdr_xfer) begin
      if (is_ip) begin
        route_q <= ROUTE_IP;
      end else if (is_arp) begin
        route_q <= ROUTE_ARP;
      end else begin
        route_q <= ROUTE_DROP;
      end
    end else if (last_xfer) begin
      route_q <= ROUTE_IDLE;
    end
  end

endmodule

`default_nettype wire

// ==== eth_pkg.sv ====
// Shared types and constants for the IPv4/ARP frame switch.
// Payload is one byte per beat; no keep signal is carried.
// Header fields follow wire order of destination, source and ethertype.
`default_nettype none

package eth_pkg;

  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] eth_type_t;
  typedef logic [7:0]  byte_t;

  localparam eth_type_t ETH_TYPE_IPV4 = 16'h0800;
  localparam eth_type_t ETH_TYPE_ARP  = 16'h0806;

  // 112-bit frame header
  typedef struct packed {
    mac_addr_t dest_mac;
    mac_addr_t src_mac;
    eth_type_t eth_type;
  } eth_hdr_t;

  // One payload beat where user flags a bad frame
  typedef struct packed {
    byte_t data;
    logic  last;
    logic  user;
  } eth_beat_t;

  typedef enum logic [1:0] {
    ROUTE_IDLE,
    ROUTE_IP,
    ROUTE_ARP,
    ROUTE_DROP
  } route_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ARP,
    ARB_IP
  } arb_state_t;

endpackage

`default_nettype wire
